// ==== include/pipe_macros.svh ====
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// Data path width
`define DATA_W 32

// Register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// Data RAM word address, 256 words, byte address bits 9:2
`define RAM_ADDR_W 8

// Cycles from the instr_valid cycle to the wb_valid cycle
`define PIPE_LATENCY 5

`endif

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    // Primary opcode field
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd8,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // Function field of R-type words
    typedef enum logic [5:0] {
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_SLT = 6'd42
    } funct_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        funct_t      funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Same 32-bit word, read as register or immediate format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

endpackage

// ==== hw/pipe_pkg.sv ====
package pipe_pkg;

    // ALU operation selected in decode
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    // Source of the register write data
    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wb_src_t;

endpackage

// ==== hw/register_file.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

module register_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] rd_addr_a,
    input  logic [`REG_ADDR_W-1:0] rd_addr_b,
    output logic [`DATA_W-1:0]     rd_data_a,
    output logic [`DATA_W-1:0]     rd_data_b,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`DATA_W-1:0]     wr_data
);

    logic [`DATA_W-1:0] regs [0:`NUM_REGS-1];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && (wr_addr != '0))  // r0 is hardwired
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous reads, r0 forced to zero
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

// ==== hw/data_ram.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

module data_ram (
    input  logic                   clk,
    input  logic [`RAM_ADDR_W-1:0] ram_addr,
    input  logic [`DATA_W-1:0]     ram_wdata,
    input  logic                   ram_we,
    output logic [`DATA_W-1:0]     ram_rdata
);

    logic [`DATA_W-1:0] mem [0:(1 << `RAM_ADDR_W)-1];

    // Read-first: a write returns the old word on the same edge
    always_ff @(posedge clk)
    begin
        if (ram_we)
        begin
            mem[ram_addr] <= ram_wdata;
        end
        ram_rdata <= mem[ram_addr];
    end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  logic [`DATA_W-1:0]     instr,
    output logic [`REG_ADDR_W-1:0] rf_addr_a,
    output logic [`REG_ADDR_W-1:0] rf_addr_b,
    input  logic [`DATA_W-1:0]     rf_data_a,
    input  logic [`DATA_W-1:0]     rf_data_b,
    output logic                   d_valid,
    output pipe_pkg::alu_op_t      alu_op,
    output logic [`DATA_W-1:0]     op_a,
    output logic [`DATA_W-1:0]     op_b,
    output logic [`DATA_W-1:0]     imm,
    output logic                   use_imm,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic                   reg_write,
    output pipe_pkg::wb_src_t      wb_src,
    output logic [`REG_ADDR_W-1:0] dest
);

    import isa_pkg::*;
    import pipe_pkg::*;

    instr_t                 iw;
    alu_op_t                op_c;
    logic                   known_c;       // Recognized instruction that writes a register
    logic                   use_imm_c;
    logic                   sext_c;        // Sign-extend the immediate
    logic                   load_c;
    logic                   store_c;
    logic [`REG_ADDR_W-1:0] dest_c;
    logic [`DATA_W-1:0]     imm_c;

    assign iw        = instr;
    assign rf_addr_a = iw.r.rs;
    assign rf_addr_b = iw.r.rt;

    always_comb
    begin
        op_c      = ALU_ADD;
        known_c   = 1'b0;
        use_imm_c = 1'b1;
        sext_c    = 1'b1;
        load_c    = 1'b0;
        store_c   = 1'b0;
        dest_c    = iw.i.rt;              // I-type writes rt
        case (iw.r.opcode)
            OP_RTYPE:
            begin
                use_imm_c = 1'b0;
                dest_c    = iw.r.rd;
                known_c   = 1'b1;
                case (iw.r.funct)
                    FN_ADD:  op_c = ALU_ADD;
                    FN_SUB:  op_c = ALU_SUB;
                    FN_AND:  op_c = ALU_AND;
                    FN_OR:   op_c = ALU_OR;
                    FN_SLT:  op_c = ALU_SLT;
                    default: known_c = 1'b0;  // Retires with no write
                endcase
            end
            OP_ADDI: known_c = 1'b1;
            OP_ANDI:
            begin
                op_c    = ALU_AND;
                sext_c  = 1'b0;
                known_c = 1'b1;
            end
            OP_ORI:
            begin
                op_c    = ALU_OR;
                sext_c  = 1'b0;
                known_c = 1'b1;
            end
            OP_LW:
            begin
                load_c  = 1'b1;
                known_c = 1'b1;
            end
            OP_SW:   store_c = 1'b1;          // Address add, no register write
            default: use_imm_c = 1'b0;
        endcase
    end

    assign imm_c = sext_c ? {{(`DATA_W-16){iw.i.imm[15]}}, iw.i.imm}
                          : {{(`DATA_W-16){1'b0}}, iw.i.imm};

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            d_valid   <= 1'b0;
            alu_op    <= ALU_ADD;
            op_a      <= '0;
            op_b      <= '0;
            imm       <= '0;
            use_imm   <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            reg_write <= 1'b0;
            wb_src    <= WB_ALU;
            dest      <= '0;
        end
        else
        begin
            d_valid   <= instr_valid;
            alu_op    <= op_c;
            op_a      <= rf_data_a;
            op_b      <= rf_data_b;
            imm       <= imm_c;
            use_imm   <= use_imm_c;
            mem_read  <= load_c;
            mem_write <= store_c;
            reg_write <= known_c && (dest_c != '0);
            wb_src    <= load_c ? WB_MEM : WB_ALU;
            dest      <= dest_c;
        end
    end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   d_valid,
    input  pipe_pkg::alu_op_t      alu_op,
    input  logic [`DATA_W-1:0]     op_a,
    input  logic [`DATA_W-1:0]     op_b,
    input  logic [`DATA_W-1:0]     imm,
    input  logic                   use_imm,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  logic                   reg_write,
    input  pipe_pkg::wb_src_t      wb_src,
    input  logic [`REG_ADDR_W-1:0] dest,
    output logic                   e_valid,
    output logic [`DATA_W-1:0]     alu_result,
    output logic [`DATA_W-1:0]     store_data,
    output logic                   mem_read_out,
    output logic                   mem_write_out,
    output logic                   reg_write_out,
    output pipe_pkg::wb_src_t      wb_src_out,
    output logic [`REG_ADDR_W-1:0] dest_out
);

    import pipe_pkg::*;

    logic [`DATA_W-1:0] b_sel;
    logic [`DATA_W-1:0] alu_c;

    assign b_sel = use_imm ? imm : op_b;

    always_comb
    begin
        case (alu_op)
            ALU_SUB: alu_c = op_a - b_sel;
            ALU_AND: alu_c = op_a & b_sel;
            ALU_OR:  alu_c = op_a | b_sel;
            ALU_SLT: alu_c = {{(`DATA_W-1){1'b0}}, ($signed(op_a) < $signed(b_sel))};
            default: alu_c = op_a + b_sel;    // add, also load/store address
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            e_valid       <= 1'b0;
            alu_result    <= '0;
            store_data    <= '0;
            mem_read_out  <= 1'b0;
            mem_write_out <= 1'b0;
            reg_write_out <= 1'b0;
            wb_src_out    <= WB_ALU;
            dest_out      <= '0;
        end
        else
        begin
            e_valid       <= d_valid;
            alu_result    <= alu_c;
            store_data    <= op_b;            // rt value for sw
            mem_read_out  <= mem_read;
            mem_write_out <= mem_write;
            reg_write_out <= reg_write;
            wb_src_out    <= wb_src;
            dest_out      <= dest;
        end
    end

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

module memory_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   e_valid,
    input  logic [`DATA_W-1:0]     alu_result,
    input  logic [`DATA_W-1:0]     store_data,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  logic                   reg_write,
    input  pipe_pkg::wb_src_t      wb_src,
    input  logic [`REG_ADDR_W-1:0] dest,
    output logic [`RAM_ADDR_W-1:0] ram_addr,
    output logic [`DATA_W-1:0]     ram_wdata,
    output logic                   ram_we,
    input  logic [`DATA_W-1:0]     ram_rdata,
    output logic                   m_valid,
    output logic [`DATA_W-1:0]     alu_result_out,
    output logic [`DATA_W-1:0]     load_data,
    output logic                   reg_write_out,
    output pipe_pkg::wb_src_t      wb_src_out,
    output logic [`REG_ADDR_W-1:0] dest_out
);

    import pipe_pkg::*;

    // First bank, valid during the RAM access cycle
    logic                   valid_q;
    logic [`DATA_W-1:0]     alu_q;
    logic                   reg_write_q;
    wb_src_t                wb_src_q;
    logic [`REG_ADDR_W-1:0] dest_q;
    logic                   access_c;

    // RAM address only moves on a real load or store
    assign access_c = e_valid && (mem_read || mem_write);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            valid_q     <= 1'b0;
            alu_q       <= '0;
            reg_write_q <= 1'b0;
            wb_src_q    <= WB_ALU;
            dest_q      <= '0;
            ram_addr    <= '0;
            ram_wdata   <= '0;
            ram_we      <= 1'b0;
        end
        else
        begin
            valid_q     <= e_valid;
            alu_q       <= alu_result;
            reg_write_q <= reg_write;
            wb_src_q    <= wb_src;
            dest_q      <= dest;
            ram_we      <= e_valid && mem_write;  // One-cycle write strobe
            if (access_c)
            begin
                ram_addr  <= alu_result[`RAM_ADDR_W+1:2];  // Word address
                ram_wdata <= store_data;
            end
        end
    end

    // Second bank lines up with the registered RAM output
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            m_valid        <= 1'b0;
            alu_result_out <= '0;
            reg_write_out  <= 1'b0;
            wb_src_out     <= WB_ALU;
            dest_out       <= '0;
        end
        else
        begin
            m_valid        <= valid_q;
            alu_result_out <= alu_q;
            reg_write_out  <= reg_write_q;
            wb_src_out     <= wb_src_q;
            dest_out       <= dest_q;
        end
    end

    assign load_data = ram_rdata;

endmodule

// ==== hw/writeback_stage.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

module writeback_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   m_valid,
    input  logic [`DATA_W-1:0]     alu_result,
    input  logic [`DATA_W-1:0]     load_data,
    input  logic                   reg_write,
    input  pipe_pkg::wb_src_t      wb_src,
    input  logic [`REG_ADDR_W-1:0] dest,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_dest,
    output logic [`DATA_W-1:0]     wb_data
);

    import pipe_pkg::*;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_valid <= 1'b0;
            wb_dest  <= '0;
            wb_data  <= '0;
        end
        else
        begin
            wb_valid <= m_valid && reg_write;  // Retire strobe, also RF write enable
            wb_dest  <= dest;
            wb_data  <= (wb_src == WB_MEM) ? load_data : alu_result;
        end
    end

endmodule

// ==== hw/pipe_core.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

// wb_valid follows instr_valid by `PIPE_LATENCY cycles, no stalls
module pipe_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  logic [`DATA_W-1:0]     instr,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_dest,
    output logic [`DATA_W-1:0]     wb_data
);

    import pipe_pkg::*;

    logic [`REG_ADDR_W-1:0] rf_addr_a, rf_addr_b;
    logic [`DATA_W-1:0]     rf_data_a, rf_data_b;

    // Decode to execute
    logic                   d_valid, d_use_imm, d_mem_read, d_mem_write, d_reg_write;
    alu_op_t                d_alu_op;
    wb_src_t                d_wb_src;
    logic [`DATA_W-1:0]     d_op_a, d_op_b, d_imm;
    logic [`REG_ADDR_W-1:0] d_dest;

    // Execute to memory
    logic                   e_valid, e_mem_read, e_mem_write, e_reg_write;
    wb_src_t                e_wb_src;
    logic [`DATA_W-1:0]     e_alu_result, e_store_data;
    logic [`REG_ADDR_W-1:0] e_dest;

    // Memory to RAM and writeback
    logic [`RAM_ADDR_W-1:0] ram_addr;
    logic [`DATA_W-1:0]     ram_wdata, ram_rdata;
    logic                   ram_we;
    logic                   m_valid, m_reg_write;
    wb_src_t                m_wb_src;
    logic [`DATA_W-1:0]     m_alu_result, m_load_data;
    logic [`REG_ADDR_W-1:0] m_dest;

    register_file u_rf (
        .clk(clk), .rst(rst),
        .rd_addr_a(rf_addr_a), .rd_addr_b(rf_addr_b),
        .rd_data_a(rf_data_a), .rd_data_b(rf_data_b),
        .wr_en(wb_valid), .wr_addr(wb_dest), .wr_data(wb_data)  // Same regs as retire
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
        .rf_addr_a(rf_addr_a), .rf_addr_b(rf_addr_b),
        .rf_data_a(rf_data_a), .rf_data_b(rf_data_b),
        .d_valid(d_valid), .alu_op(d_alu_op), .op_a(d_op_a), .op_b(d_op_b),
        .imm(d_imm), .use_imm(d_use_imm), .mem_read(d_mem_read),
        .mem_write(d_mem_write), .reg_write(d_reg_write), .wb_src(d_wb_src),
        .dest(d_dest)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .d_valid(d_valid), .alu_op(d_alu_op),
        .op_a(d_op_a), .op_b(d_op_b), .imm(d_imm), .use_imm(d_use_imm),
        .mem_read(d_mem_read), .mem_write(d_mem_write), .reg_write(d_reg_write),
        .wb_src(d_wb_src), .dest(d_dest),
        .e_valid(e_valid), .alu_result(e_alu_result), .store_data(e_store_data),
        .mem_read_out(e_mem_read), .mem_write_out(e_mem_write),
        .reg_write_out(e_reg_write), .wb_src_out(e_wb_src), .dest_out(e_dest)
    );

    memory_stage u_memory (
        .clk(clk), .rst(rst), .e_valid(e_valid), .alu_result(e_alu_result),
        .store_data(e_store_data), .mem_read(e_mem_read), .mem_write(e_mem_write),
        .reg_write(e_reg_write), .wb_src(e_wb_src), .dest(e_dest),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we),
        .ram_rdata(ram_rdata), .m_valid(m_valid), .alu_result_out(m_alu_result),
        .load_data(m_load_data), .reg_write_out(m_reg_write),
        .wb_src_out(m_wb_src), .dest_out(m_dest)
    );

    data_ram u_ram (
        .clk(clk), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .ram_we(ram_we), .ram_rdata(ram_rdata)
    );

    writeback_stage u_writeback (
        .clk(clk), .rst(rst), .m_valid(m_valid), .alu_result(m_alu_result),
        .load_data(m_load_data), .reg_write(m_reg_write), .wb_src(m_wb_src),
        .dest(m_dest), .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data)
    );

endmodule

// ==== verif/pipe_tb.sv ====
`timescale 1ns/1ps
`include "pipe_macros.svh"

module pipe_tb;

    localparam int PERIOD     = 100;
    localparam int RST_CYC    = 10;
    localparam int IDLE_CYC   = 8;      // Quiet cycles after reset
    localparam int MAX_VEC    = 64;
    localparam int FIELDS     = 5;      // Gap, instr, write flag, dest, data
    localparam int NUM_GROUPS = 6;

    logic                   clk;
    logic                   rst;
    logic                   instr_valid;
    logic [`DATA_W-1:0]     instr;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_dest;
    logic [`DATA_W-1:0]     wb_data;

    logic [31:0]            vec_mem [0:MAX_VEC*FIELDS-1];
    int                     num_vec = 0;
    int                     max_gap = 0;
    int                     wd_cycles = 0;
    int                     cyc = 0;         // Advances on every rising edge
    int                     last_issue = 0;
    int                     errors = 0;
    int                     checks = 0;
    logic [31:0]            rng_state;

    // Pending register writes in issue order
    int                     exp_cycle [$];
    logic [`REG_ADDR_W-1:0] exp_dest [$];
    logic [`DATA_W-1:0]     exp_data [$];

    pipe_core u_dut (
        .clk(clk),
        .rst(rst),
        .instr_valid(instr_valid),
        .instr(instr),
        .wb_valid(wb_valid),
        .wb_dest(wb_dest),
        .wb_data(wb_data)
    );

    initial clk = 1'b0;
    always #(PERIOD/2) clk = ~clk;

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int group_first(input int g);
        case (g)
            0:       return 0;
            1:       return 1;
            2:       return 6;
            3:       return 12;
            4:       return 16;
            default: return 20;
        endcase
    endfunction

    function automatic string group_label(input int g);
        case (g)
            0:       return "reset and zero reads";
            1:       return "immediate extension";
            2:       return "R-type ALU";
            3:       return "store and load";
            4:       return "back to back issue";
            default: return "suppressed writes";
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic load_vectors();
        for (int i = 0; i < MAX_VEC * FIELDS; i++)
        begin
            vec_mem[i] = 'x;
        end
        $readmemh("verif/pipe_vectors.hex", vec_mem);
        while (num_vec < MAX_VEC && !$isunknown(vec_mem[num_vec*FIELDS + FIELDS - 1]))
        begin
            if (vec_mem[num_vec*FIELDS] > max_gap)
                max_gap = vec_mem[num_vec*FIELDS];
            num_vec++;
        end
    endtask

    // Entered just after a rising edge and left one edge after the issue
    task automatic issue_vector(input int idx);
        int gap;
        int extra;
        gap   = vec_mem[idx*FIELDS];
        extra = 0;
        if (gap != 0)
        begin
            rng_state = xorshift(rng_state);
            extra     = rng_state[1:0];   // Gap 0 keeps back to back issue
        end
        instr_valid <= 1'b0;
        repeat (gap + extra) @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= vec_mem[idx*FIELDS + 1];
        last_issue   = cyc + 1;
        if (vec_mem[idx*FIELDS + 2][0])
        begin
            exp_cycle.push_back(cyc + 1);
            exp_dest.push_back(vec_mem[idx*FIELDS + 3][`REG_ADDR_W-1:0]);
            exp_data.push_back(vec_mem[idx*FIELDS + 4]);
        end
        @(posedge clk);
    endtask

    // Also covers writes that must not appear after the last issue
    task automatic wait_drained();
        while (exp_cycle.size() != 0 || cyc <= last_issue + `PIPE_LATENCY)
            @(posedge clk);
    endtask

    task automatic drop_front();
        exp_cycle.delete(0);
        exp_dest.delete(0);
        exp_data.delete(0);
    endtask

    // Retire monitor on the falling edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (exp_cycle.size() > 0 && cyc > exp_cycle[0] + `PIPE_LATENCY)
            begin
                errors++;
                $display("Write to r%0d issued in cycle %0d never arrived",
                         exp_dest[0], exp_cycle[0]);
                drop_front();
            end
            if (wb_valid === 1'b1)
            begin
                if (exp_cycle.size() > 0 && cyc == exp_cycle[0] + `PIPE_LATENCY)
                begin
                    compare("wb_dest", wb_dest, exp_dest[0]);
                    compare("wb_data", wb_data, exp_data[0]);
                    drop_front();
                end
                else
                begin
                    errors++;
                    $display("Unexpected register write to r%0d in cycle %0d", wb_dest, cyc);
                end
            end
            else if (wb_valid !== 1'b0)
            begin
                errors++;
                $display("wb_valid is unknown in cycle %0d", cyc);
            end
        end
    end

    initial
    begin
        wait (wd_cycles > 0);
        #(wd_cycles * PERIOD);
        $display("Timeout after %0d cycles, the pipeline did not finish", wd_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        int first;
        int last;
        int errors_at_start;

        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rng_state   = 32'h577;
        load_vectors();
        wd_cycles = num_vec * (max_gap + 3 + `PIPE_LATENCY + 2) + RST_CYC + IDLE_CYC;

        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;
        repeat (IDLE_CYC) @(posedge clk);   // Nothing may retire here

        if (num_vec == 0)
        begin
            errors++;
            $display("No vectors could be read from verif/pipe_vectors.hex");
        end

        for (int g = 0; g < NUM_GROUPS; g++)
        begin
            first  = group_first(g);
            last   = (g == NUM_GROUPS - 1) ? num_vec : group_first(g + 1);
            if (last > num_vec)
                last = num_vec;
            errors_at_start = errors;
            for (int v = first; v < last; v++)
            begin
                issue_vector(v);
            end
            instr_valid <= 1'b0;
            wait_drained();
            $display("Group %0d, %s: %0d errors", g + 1, group_label(g),
                     errors - errors_at_start);
        end

        $display("Vectors %0d, checks %0d, errors %0d", num_vec, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/register_file.sv
hw/data_ram.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/writeback_stage.sv
hw/pipe_core.sv
verif/pipe_tb.sv

// ==== verif/pipe_vectors.hex ====
// gap  instr     wr dest data
// gap is idle cycles before issue, wr is 1 when a register write must retire
05 00221820 1 03 00000000
05 20011234 1 01 00001234
01 2002FFFB 1 02 FFFFFFFB
01 34048001 1 04 00008001
05 3045F0F0 1 05 0000F0F0
01 2026FFCC 1 06 00001200
01 00243820 1 07 00009235
01 00244022 1 08 FFFF9233
01 00224824 1 09 00001230
01 00445025 1 0A FFFFFFFB
01 0041582A 1 0B 00000001
01 0022602A 1 0C 00000000
01 AC010040 0 00 00000000
01 AC020044 0 00 00000000
01 8C0D0040 1 0D 00001234
01 8C0E0044 1 0E FFFFFFFB
01 341000AA 1 10 000000AA
00 20310001 1 11 00001235
00 8C120040 1 12 00001234
00 00819822 1 13 00006DCD
01 00240020 0 00 00000000
00 FC0A1234 0 00 00000000
05 0000A020 1 14 00000000
00 0140A820 1 15 FFFFFFFB
